// ==== sources.f ====
+incdir+test
common/cpu_sm_pkg.sv
logic/bus_input_sync.sv
cpu_sm/cpu_sm_seq.sv
cpu_sm/cpu_sm_outputs.sv
cpu_sm/cpu_sm.sv
test/tb_cpu_sm.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the sequencer testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_cpu_sm \
    -Mdir obj_dir -o sim_cpu_sm
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_cpu_sm > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// ==== test/cpu_sm_model.svh ====
/* Reference rules for the sequencer testbench. Counts cover one longword transfer,
   so a 16-bit port gives two bus cycles and a 32-bit port one. */
`ifndef CPU_SM_MODEL_SVH
`define CPU_SM_MODEL_SVH
`default_nettype none

// Enabled, pending request with room for a read or data for a write
function automatic logic request_ok(input logic ena, input logic req_, input logic dir,
                                    input logic full, input logic empty);
    return ena && !req_ && (dir ? !full : !empty);
endfunction

// Port size implied by the number of address strobes in one transfer
function automatic cpu_sm_pkg::port_size_t size_from_cycles(input int n);
    case (n)
        1: return cpu_sm_pkg::port_32;
        2: return cpu_sm_pkg::port_16;
        default: return cpu_sm_pkg::port_none;
    endcase
endfunction

// Only the word cycle of a 16-bit port runs at word size
function automatic int size1_cycles(input cpu_sm_pkg::port_size_t sz);
    return (sz == cpu_sm_pkg::port_16) ? 1 : 0;
endfunction

// Writes drive the high word in the first cycle only
function automatic int high_drives(input logic dir);
    return dir ? 0 : 1;
endfunction

// The low word goes out in every write cycle
function automatic int low_drives(input cpu_sm_pkg::port_size_t sz, input logic dir);
    return dir ? 0 : ((sz == cpu_sm_pkg::port_16) ? 2 : 1);
endfunction

// One pulse per latch and one FIFO pulse per longword
function automatic int read_pulses(input logic dir);
    return dir ? 1 : 0;
endfunction

// A 32-bit read latches both halves on one edge
function automatic int joint_latches(input cpu_sm_pkg::port_size_t sz, input logic dir);
    return (dir && sz == cpu_sm_pkg::port_32) ? 1 : 0;
endfunction

`default_nettype wire
`endif

// ==== test/tb_cpu_sm.sv ====
/* Testbench for the DMA sequencer. The bus slave answers each cycle after a wait chosen
   per transfer; another master may hold the bus once while a request is pending. */
`timescale 1ns/1ps
`include "cpu_sm_model.svh"
`default_nettype none

module tb_cpu_sm;

    localparam int n_random     = 56;
    localparam int n_directed   = 8;
    localparam int reset_cycles = 10;
    // Slowest transfer takes about 30 cycles
    localparam int cycle_limit  = (n_random + n_directed) * 40 + reset_cycles;

    typedef enum int {c_pas, c_pds, c_size1, c_hi, c_lo, c_plhw, c_pllw, c_both,
                      c_inc, c_dec} count_t;

    logic BCLK = 1'b0;
    logic CCRESET_;
    logic dmaena;
    logic dreq_;
    logic dmadir;
    logic fifofull;
    logic fifoempty;
    logic sterm_ = 1'b1;
    // Bus side, driven by the slave responder
    logic bgrant_ = 1'b1;
    logic bgack_i_ = 1'b1;
    logic as_ = 1'b1;
    logic dsack0_ = 1'b1;
    logic dsack1_ = 1'b1;
    logic breq, bgack, pas, pds, size1, f2cpuh, f2cpul;
    logic dieh, diel, plhw, pllw, incfifo, decfifo;

    integer seed = 43;
    integer rnd;
    int errors = 0;
    int mon_errors = 0;
    int tests = 0;
    int mark = 0;
    int cycles = 0;
    int cnt [10] = '{default: 0};
    int base [10];
    int inc_base = 0;
    int dec_base = 0;
    int reads_ok = 0;
    int writes_ok = 0;
    logic [12:0] outs;
    string out_names [13] = '{"decfifo", "incfifo", "pllw", "plhw", "diel", "dieh", "f2cpul",
                              "f2cpuh", "size1", "pds", "pas", "bgack", "breq"};
    // Responder behavior for the current transfer
    cpu_sm_pkg::port_size_t slave_size = cpu_sm_pkg::port_32;
    int slave_wait = 0;
    int grant_wait = 0;
    logic contend = 1'b0;
    int wait_cnt = 0;
    int grant_cnt = 0;
    logic contended = 1'b0;
    logic pas_q = 1'b0;
    logic pds_q = 1'b0;
    logic breq_q = 1'b0;
    logic bgack_q = 1'b0;
    logic pulse_q = 1'b0;
    logic idle_q1 = 1'b0;
    logic idle_q2 = 1'b0;

    cpu_sm dut (.*);

    always #20 BCLK = ~BCLK;

    always @(posedge BCLK) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, a transfer never completed", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic check_bit(input string name, input logic got, input logic exp,
                             inout int err);
        if (got !== exp) begin
            err++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_size(input string name, input cpu_sm_pkg::port_size_t got,
                              input cpu_sm_pkg::port_size_t exp, inout int err);
        if (got !== exp) begin
            err++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp, inout int err);
        if (got != exp) begin
            err++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Bus monitor and slave responder, both working on the falling edge
    always @(negedge BCLK) begin
        if (CCRESET_) begin
            if (pas && !bgack) begin
                mon_errors++;
                $display("pas asserted while the bus is not owned");
            end
            if (pds) begin
                check_bit("dieh", dieh, dmadir, mon_errors);
                check_bit("diel", diel, dmadir, mon_errors);
            end
            if (breq && !breq_q && !request_ok(dmaena, dreq_, dmadir, fifofull, fifoempty)) begin
                mon_errors++;
                $display("breq rose although the request rule did not hold");
            end
            if (bgack && !bgack_q) begin
                check_bit("breq", breq, 1'b0, mon_errors);
                if (!idle_q2) begin
                    mon_errors++;
                    $display("bgack rose without a grant on an idle bus");
                end
            end
            // Bus is released on the cycle after the FIFO strobe
            if (pulse_q) begin
                check_bit("bgack", bgack, 1'b0, mon_errors);
            end
            if (pas && !pas_q) begin
                // Second address strobe of a transfer is the word cycle
                check_bit("size1", size1, cnt[c_pas] != base[c_pas], mon_errors);
                check_bit("f2cpuh", f2cpuh, !dmadir && cnt[c_pas] == base[c_pas], mon_errors);
                cnt[c_pas]++;
                cnt[c_size1] += int'(size1);
                cnt[c_hi] += int'(f2cpuh);
                cnt[c_lo] += int'(f2cpul);
            end
            if (pds && !pds_q) begin
                cnt[c_pds]++;
            end
            cnt[c_plhw] += int'(plhw);
            cnt[c_pllw] += int'(pllw);
            cnt[c_both] += int'(plhw & pllw);
            cnt[c_inc] += int'(incfifo);
            cnt[c_dec] += int'(decfifo);
        end
        pas_q = pas;
        pds_q = pds;
        breq_q = breq;
        bgack_q = bgack;
        pulse_q = incfifo | decfifo;
        as_ = ~pas;
        if (!pas) begin
            dsack0_ = 1'b1;
            dsack1_ = 1'b1;
            wait_cnt = 0;
        end else if (wait_cnt >= slave_wait) begin
            dsack1_ = 1'b0;
            dsack0_ = (slave_size == cpu_sm_pkg::port_16);
        end else begin
            wait_cnt++;
        end
        bgack_i_ = 1'b1;
        if (!breq) begin
            bgrant_ = 1'b1;
            grant_cnt = 0;
            contended = 1'b0;
        end else begin
            if (contend && !contended) begin
                bgack_i_ = 1'b0;
                contended = 1'b1;
            end
            if (grant_cnt >= grant_wait) begin
                bgrant_ = 1'b0;
            end else begin
                grant_cnt++;
            end
        end
        idle_q2 = idle_q1;
        idle_q1 = !bgrant_ && bgack_i_ && as_ && dsack0_ && dsack1_ && sterm_;
    end

    task automatic start_test();
        mark = errors + mon_errors;
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors + mon_errors == mark) begin
            $display("test %-14s pass", name);
        end else begin
            $display("test %-14s FAILED", name);
        end
    endtask

    // One request; an accepted one runs to the end of its tenure and is counted
    task automatic run_attempt(input logic dir, input cpu_sm_pkg::port_size_t sz,
                               input logic ena, input logic full, input logic empty);
        int d [10];
        base = cnt;
        slave_size = sz;
        slave_wait = {$random(seed)} % 6;
        grant_wait = {$random(seed)} % 4;
        contend = ($random(seed) & 3) == 0;
        dmadir = dir;
        dmaena = ena;
        fifofull = full;
        fifoempty = empty;
        dreq_ = 1'b0;
        if (request_ok(ena, 1'b0, dir, full, empty)) begin
            while (!(incfifo || decfifo)) @(negedge BCLK);
            dreq_ = 1'b1;
            while (bgack) @(negedge BCLK);
            foreach (d[i]) d[i] = cnt[i] - base[i];
            check_size("port size", size_from_cycles(d[c_pas]), sz, errors);
            check_size("pds cycles", size_from_cycles(d[c_pds]), sz, errors);
            check_count("size1", d[c_size1], size1_cycles(sz), errors);
            check_count("f2cpuh", d[c_hi], high_drives(dir), errors);
            check_count("f2cpul", d[c_lo], low_drives(sz, dir), errors);
            check_count("plhw", d[c_plhw], read_pulses(dir), errors);
            check_count("pllw", d[c_pllw], read_pulses(dir), errors);
            check_count("plhw with pllw", d[c_both], joint_latches(sz, dir), errors);
            check_count("incfifo", d[c_inc], read_pulses(dir), errors);
            check_count("decfifo", d[c_dec], read_pulses(~dir), errors);
            if (dir) begin
                reads_ok++;
            end else begin
                writes_ok++;
            end
        end else begin
            repeat (6) begin
                @(negedge BCLK);
                check_bit("breq", breq, 1'b0, errors);
            end
            dreq_ = 1'b1;
        end
        repeat (2) @(negedge BCLK);
    endtask

    initial begin
        CCRESET_ = 1'b0;
        dmaena = 1'b0;
        dreq_ = 1'b1;
        dmadir = 1'b0;
        fifofull = 1'b0;
        fifoempty = 1'b0;
        repeat (reset_cycles) @(negedge BCLK);
        CCRESET_ = 1'b1;
        @(negedge BCLK);

        start_test();
        outs = {breq, bgack, pas, pds, size1, f2cpuh, f2cpul, dieh, diel, plhw, pllw,
                incfifo, decfifo};
        foreach (outs[i]) check_bit(out_names[i], outs[i], 1'b0, errors);
        finish_test("reset");

        start_test();
        run_attempt(1'b0, cpu_sm_pkg::port_32, 1'b1, 1'b0, 1'b0);
        finish_test("arbitration");

        start_test();
        run_attempt(1'b1, cpu_sm_pkg::port_32, 1'b1, 1'b0, 1'b0);
        finish_test("32-bit read");

        start_test();
        run_attempt(1'b0, cpu_sm_pkg::port_16, 1'b1, 1'b0, 1'b0);
        finish_test("16-bit write");

        // Disabled, read into a full FIFO, write from an empty FIFO
        start_test();
        run_attempt(1'b1, cpu_sm_pkg::port_32, 1'b0, 1'b0, 1'b0);
        run_attempt(1'b1, cpu_sm_pkg::port_32, 1'b1, 1'b1, 1'b0);
        run_attempt(1'b0, cpu_sm_pkg::port_32, 1'b1, 1'b0, 1'b1);
        finish_test("blocked");

        start_test();
        reads_ok = 0;
        writes_ok = 0;
        inc_base = cnt[c_inc];
        dec_base = cnt[c_dec];
        repeat (n_random) begin
            rnd = $random(seed);
            run_attempt(rnd[0], rnd[1] ? cpu_sm_pkg::port_16 : cpu_sm_pkg::port_32,
                        rnd[4:2] != 3'd0, rnd[7:5] == 3'd0, rnd[10:8] == 3'd0);
        end
        check_count("incfifo total", cnt[c_inc] - inc_base, reads_ok, errors);
        check_count("decfifo total", cnt[c_dec] - dec_base, writes_ok, errors);
        finish_test("random run");

        $display("%0d tests run, %0d errors", tests, errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cpu_sm/cpu_sm.sv ====
/* DMA bus-master sequencer top: one longword per bus tenure on 16 or 32-bit ports.
   Single clock BCLK; no STERM_ termination, flush or byte-lane bridging. */
`timescale 1ns/1ps
`default_nettype none

module cpu_sm (
    input  logic BCLK,
    input  logic CCRESET_,
    input  logic dmaena,
    input  logic dreq_,
    input  logic dmadir,
    input  logic fifofull,
    input  logic fifoempty,
    input  logic bgrant_,
    input  logic bgack_i_,
    input  logic as_,
    input  logic dsack0_,
    input  logic dsack1_,
    input  logic sterm_,
    output logic breq,
    output logic bgack,
    output logic pas,
    output logic pds,
    output logic size1,
    output logic f2cpuh,
    output logic f2cpul,
    output logic dieh,
    output logic diel,
    output logic plhw,
    output logic pllw,
    output logic incfifo,
    output logic decfifo
);

    logic                   dmaena_s;
    logic                   dreq_s_;
    logic                   bgrant_s_;
    logic                   bus_busy;
    cpu_sm_pkg::port_size_t port_size;
    cpu_sm_pkg::sm_state_t  next_state;
    logic                   second_word;

    bus_input_sync u_sync (
        .BCLK      (BCLK),
        .CCRESET_  (CCRESET_),
        .dmaena    (dmaena),
        .dreq_     (dreq_),
        .bgrant_   (bgrant_),
        .bgack_i_  (bgack_i_),
        .as_       (as_),
        .dsack0_   (dsack0_),
        .dsack1_   (dsack1_),
        .sterm_    (sterm_),
        .dmaena_s  (dmaena_s),
        .dreq_s_   (dreq_s_),
        .bgrant_s_ (bgrant_s_),
        .bus_busy  (bus_busy),
        .port_size (port_size)
    );

    // Current state is only used inside the sequencer
    cpu_sm_seq u_seq (
        .BCLK        (BCLK),
        .CCRESET_    (CCRESET_),
        .dmaena_s    (dmaena_s),
        .dreq_s_     (dreq_s_),
        .bgrant_s_   (bgrant_s_),
        .bus_busy    (bus_busy),
        .port_size   (port_size),
        .dmadir      (dmadir),
        .fifofull    (fifofull),
        .fifoempty   (fifoempty),
        .state       (),
        .next_state  (next_state),
        .second_word (second_word)
    );

    cpu_sm_outputs u_outputs (
        .BCLK        (BCLK),
        .CCRESET_    (CCRESET_),
        .next_state  (next_state),
        .second_word (second_word),
        .dmadir      (dmadir),
        .breq        (breq),
        .bgack       (bgack),
        .pas         (pas),
        .pds         (pds),
        .size1       (size1),
        .f2cpuh      (f2cpuh),
        .f2cpul      (f2cpul),
        .dieh        (dieh),
        .diel        (diel),
        .plhw        (plhw),
        .pllw        (pllw),
        .incfifo     (incfifo),
        .decfifo     (decfifo)
    );

endmodule

`default_nettype wire

// ==== cpu_sm/cpu_sm_outputs.sv ====
/* Bus and FIFO strobes, decoded from the next state and registered with the state.
   The first cycle of a write drives both words since the port size is not yet known. */
`timescale 1ns/1ps
`default_nettype none

module cpu_sm_outputs (
    input  logic                  BCLK,
    input  logic                  CCRESET_,
    input  cpu_sm_pkg::sm_state_t next_state,
    input  logic                  second_word,
    input  logic                  dmadir,
    output logic                  breq,
    output logic                  bgack,
    output logic                  pas,
    output logic                  pds,
    output logic                  size1,
    output logic                  f2cpuh,
    output logic                  f2cpul,
    output logic                  dieh,
    output logic                  diel,
    output logic                  plhw,
    output logic                  pllw,
    output logic                  incfifo,
    output logic                  decfifo
);

    logic rd;
    logic in_cycle;
    logic in_data;
    logic term_first;
    logic term_last;
    logic tenure;

    assign rd         = dmadir;
    assign in_cycle   = (next_state == cpu_sm_pkg::s_addr) || (next_state == cpu_sm_pkg::s_data);
    assign in_data    = next_state == cpu_sm_pkg::s_data;
    // s_next is only entered on the first half of a 16-bit transfer
    assign term_first = next_state == cpu_sm_pkg::s_next;
    assign term_last  = next_state == cpu_sm_pkg::s_done;
    assign tenure     = next_state inside {cpu_sm_pkg::s_ack, cpu_sm_pkg::s_addr,
                                           cpu_sm_pkg::s_data, cpu_sm_pkg::s_next,
                                           cpu_sm_pkg::s_done};

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            breq    <= 1'b0;
            bgack   <= 1'b0;
            pas     <= 1'b0;
            pds     <= 1'b0;
            size1   <= 1'b0;
            f2cpuh  <= 1'b0;
            f2cpul  <= 1'b0;
            dieh    <= 1'b0;
            diel    <= 1'b0;
            plhw    <= 1'b0;
            pllw    <= 1'b0;
            incfifo <= 1'b0;
            decfifo <= 1'b0;
        end else begin
            breq    <= next_state == cpu_sm_pkg::s_req;
            bgack   <= tenure;
            pas     <= in_cycle;
            pds     <= in_data;
            size1   <= in_cycle & second_word;
            // High word only goes out on the first cycle
            f2cpuh  <= ~rd & in_cycle & ~second_word;
            f2cpul  <= ~rd & in_cycle;
            dieh    <= rd & in_data;
            diel    <= rd & in_data;
            // A 32-bit port ends without a word cycle and latches both halves at once
            plhw    <= rd & (term_first | (term_last & ~second_word));
            pllw    <= rd & term_last;
            incfifo <= rd & term_last;
            decfifo <= ~rd & term_last;
        end
    end

    a_pds_in_pas: assert property (
        @(posedge BCLK) disable iff (!CCRESET_)
        pds |-> pas
    );

endmodule

`default_nettype wire

// ==== cpu_sm/cpu_sm_seq.sv ====
/* State register and next-state logic of the sequencer. dmadir and the FIFO flags
   must be synchronous to BCLK; all other inputs arrive already registered. */
`timescale 1ns/1ps
`default_nettype none

module cpu_sm_seq (
    input  logic                   BCLK,
    input  logic                   CCRESET_,
    input  logic                   dmaena_s,
    input  logic                   dreq_s_,
    input  logic                   bgrant_s_,
    input  logic                   bus_busy,
    input  cpu_sm_pkg::port_size_t port_size,
    input  logic                   dmadir,
    input  logic                   fifofull,
    input  logic                   fifoempty,
    output cpu_sm_pkg::sm_state_t  state,
    output cpu_sm_pkg::sm_state_t  next_state,
    output logic                   second_word
);

    logic fifo_ready;
    logic request;

    // Room for a longword on reads, a longword present on writes
    assign fifo_ready = dmadir ? ~fifofull : ~fifoempty;
    assign request    = dmaena_s & ~dreq_s_ & fifo_ready;

    always_comb begin
        next_state = state;
        case (state)
            cpu_sm_pkg::s_idle: begin
                if (request) begin
                    next_state = cpu_sm_pkg::s_req;
                end
            end
            cpu_sm_pkg::s_req: begin
                // Wait for our grant and for the last master to leave the bus
                if (!bgrant_s_ && !bus_busy) begin
                    next_state = cpu_sm_pkg::s_ack;
                end
            end
            cpu_sm_pkg::s_ack: begin
                next_state = cpu_sm_pkg::s_addr;
            end
            cpu_sm_pkg::s_addr: begin
                next_state = cpu_sm_pkg::s_data;
            end
            cpu_sm_pkg::s_data: begin
                case (port_size)
                    cpu_sm_pkg::port_32: begin
                        next_state = cpu_sm_pkg::s_done;
                    end
                    cpu_sm_pkg::port_16: begin
                        if (second_word) begin
                            next_state = cpu_sm_pkg::s_done;
                        end else begin
                            next_state = cpu_sm_pkg::s_next;
                        end
                    end
                    // No acknowledge yet, keep the strobes asserted
                    default: begin
                        next_state = cpu_sm_pkg::s_data;
                    end
                endcase
            end
            cpu_sm_pkg::s_next: begin
                // Strobes drop for a cycle, then the word cycle starts
                next_state = cpu_sm_pkg::s_addr;
            end
            cpu_sm_pkg::s_done: begin
                next_state = cpu_sm_pkg::s_idle;
            end
            default: begin
                next_state = cpu_sm_pkg::s_idle;
            end
        endcase
    end

    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            state <= cpu_sm_pkg::s_idle;
        end else begin
            state <= next_state;
        end
    end

    // Marks the word half of a 16-bit transfer, cleared as the bus is released
    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            second_word <= 1'b0;
        end else if (next_state == cpu_sm_pkg::s_next) begin
            second_word <= 1'b1;
        end else if (next_state == cpu_sm_pkg::s_idle) begin
            second_word <= 1'b0;
        end
    end

    a_done_after_data: assert property (
        @(posedge BCLK) disable iff (!CCRESET_)
        (state == cpu_sm_pkg::s_done) |-> ($past(state) == cpu_sm_pkg::s_data)
    );

    a_state_legal: assert property (
        @(posedge BCLK) disable iff (!CCRESET_)
        state inside {cpu_sm_pkg::s_idle, cpu_sm_pkg::s_req, cpu_sm_pkg::s_ack,
                      cpu_sm_pkg::s_addr, cpu_sm_pkg::s_data, cpu_sm_pkg::s_next,
                      cpu_sm_pkg::s_done}
    );

    a_word_after_16: assert property (
        @(posedge BCLK) disable iff (!CCRESET_)
        $rose(second_word) |-> ($past(port_size) == cpu_sm_pkg::port_16)
    );

endmodule

`default_nettype wire

// ==== logic/bus_input_sync.sv ====
/* Registers the asynchronous bus inputs on BCLK; every path gains one cycle.
   The dsack latch reads as none while as_ is high, so sizing only holds inside a cycle. */
`timescale 1ns/1ps
`default_nettype none

module bus_input_sync (
    input  logic                   BCLK,
    input  logic                   CCRESET_,
    input  logic                   dmaena,
    input  logic                   dreq_,
    input  logic                   bgrant_,
    input  logic                   bgack_i_,
    input  logic                   as_,
    input  logic                   dsack0_,
    input  logic                   dsack1_,
    input  logic                   sterm_,
    output logic                   dmaena_s,
    output logic                   dreq_s_,
    output logic                   bgrant_s_,
    output logic                   bus_busy,
    output cpu_sm_pkg::port_size_t port_size
);

    cpu_sm_pkg::dsack_t dsack_q;

    // Request and grant inputs, plus bus activity from any master
    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            dmaena_s  <= 1'b0;
            dreq_s_   <= 1'b1;
            bgrant_s_ <= 1'b1;
            bus_busy  <= 1'b0;
        end else begin
            dmaena_s  <= dmaena;
            dreq_s_   <= dreq_;
            bgrant_s_ <= bgrant_;
            bus_busy  <= ~(bgack_i_ & as_ & dsack0_ & dsack1_ & sterm_);
        end
    end

    // Acknowledge latch, held clear while the address strobe is negated
    always_ff @(posedge BCLK or negedge CCRESET_) begin
        if (!CCRESET_) begin
            dsack_q <= cpu_sm_pkg::dsack_none;
        end else if (as_) begin
            dsack_q <= cpu_sm_pkg::dsack_none;
        end else begin
            dsack_q <= {dsack1_, dsack0_};
        end
    end

    always_comb begin
        case (dsack_q)
            cpu_sm_pkg::dsack_32: port_size = cpu_sm_pkg::port_32;
            cpu_sm_pkg::dsack_16: port_size = cpu_sm_pkg::port_16;
            cpu_sm_pkg::dsack_8:  port_size = cpu_sm_pkg::port_8;
            default:              port_size = cpu_sm_pkg::port_none;
        endcase
    end

    // A byte port would stall the sequencer in its data state
    a_no_byte_port: assert property (
        @(posedge BCLK) disable iff (!CCRESET_)
        dsack_q != cpu_sm_pkg::dsack_8
    );

endmodule

`default_nettype wire

// ==== common/cpu_sm_pkg.sv ====
/* Types and codes shared by the DMA bus-master sequencer. dsack codes are active low,
   packed {dsack1_, dsack0_}; byte ports are decoded but not supported. */
`default_nettype none

package cpu_sm_pkg;

    // Width of the sequencer state register
    localparam int state_w = 5;

    // One longword per bus tenure, split in two word cycles on a 16-bit port
    typedef enum logic [state_w-1:0] {
        s_idle = 5'b00000,
        s_req  = 5'b00001,
        s_ack  = 5'b00011,
        s_addr = 5'b00111,
        s_data = 5'b00110,
        s_next = 5'b00100,
        s_done = 5'b01000
    } sm_state_t;

    // Latched acknowledge pair
    typedef logic [1:0] dsack_t;

    localparam dsack_t dsack_none = 2'b11;
    localparam dsack_t dsack_16   = 2'b01;
    localparam dsack_t dsack_32   = 2'b00;
    // Byte port answers on dsack0_ alone
    localparam dsack_t dsack_8    = 2'b10;

    // Decoded size of the answering port
    typedef enum logic [1:0] {
        port_none = 2'd0,
        port_8    = 2'd1,
        port_16   = 2'd2,
        port_32   = 2'd3
    } port_size_t;

endpackage

`default_nettype wire
